/* design/testchip_pkg.sv */
package testchip_pkg;

	// sram macro geometry
	localparam int ADDR_W   = 16;
	localparam int DATA_W   = 32;
	localparam int WMASK_W  = 4;   // one bit per byte lane

	// bank select carried at the top of the scan word
	localparam int SELECT_W = 4;

	// one port command as it sits in the scan word
	// csb and web are active low like on the macro pins
	typedef struct packed {
		logic [ADDR_W-1:0]  addr;
		logic [DATA_W-1:0]  din;
		logic               csb;
		logic               web;
		logic [WMASK_W-1:0] wmask;
	} sram_cmd_t;

	// complete scan word, msb first is chip_sel
	// port0 sits above port1 so a scan-out sends port0 before port1
	typedef struct packed {
		logic [SELECT_W-1:0] chip_sel;
		sram_cmd_t           port0;
		sram_cmd_t           port1;
	} scan_word_t;

	// total chain length, shifted one bit per clk on gpio
	localparam int SCAN_W = $bits(scan_word_t);

	// read data of a single bank, one word per port
	typedef struct packed {
		logic [DATA_W-1:0] data0;  // from port 0 dout
		logic [DATA_W-1:0] data1;  // from port 1 dout
	} rdata_pair_t;

	// what the scan register does on the next edge
	typedef enum logic [1:0] {
		OP_HOLD,
		OP_SHIFT,    // serial load from gpio
		OP_LOAD,     // parallel load from the logic analyzer
		OP_CAPTURE   // take read data into the din fields
	} load_op_t;

endpackage

/* design/scan_register.sv */
`timescale 1ns/1ps

module scan_register (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      gpio_in_i,    // serial data in
	input  logic                      gpio_scan_i,  // shift enable
	input  logic                      la_in_load_i,
	input  logic                      capture_i,
	input  testchip_pkg::scan_word_t  la_data_i,
	input  testchip_pkg::rdata_pair_t read_pair_i,
	output testchip_pkg::scan_word_t  scan_word_o
);

	import testchip_pkg::*;

	load_op_t   op;
	scan_word_t word_q;
	scan_word_t word_d;

	// fixed priority, shift wins over everything
	always_comb begin
		if (gpio_scan_i) begin
			op = OP_SHIFT;
		end else if (la_in_load_i) begin
			op = OP_LOAD;
		end else if (capture_i) begin
			op = OP_CAPTURE;
		end else begin
			op = OP_HOLD;
		end
	end

	always_comb begin
		word_d = word_q;
		case (op)
			OP_SHIFT: begin
				// msb drops out on gpio_out, new bit enters at lsb
				word_d = scan_word_t'({word_q[SCAN_W-2:0], gpio_in_i});
			end
			OP_LOAD: begin
				word_d = la_data_i;
			end
			OP_CAPTURE: begin
				// only the din fields are replaced
				// addr, control and select stay so the same access can be repeated
				word_d.port0.din = read_pair_i.data0;
				word_d.port1.din = read_pair_i.data1;
			end
			default: begin
				word_d = word_q;  // hold
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			word_q <= '0;
		end else begin
			word_q <= word_d;
		end
	end

	assign scan_word_o = word_q;

endmodule

/* design/port_decoder.sv */
`timescale 1ns/1ps

module port_decoder #(
	parameter int NUM_SRAMS = 16
) (
	input  testchip_pkg::scan_word_t scan_word_i,
	input  logic                     global_csb_i,  // high disables every bank
	output testchip_pkg::sram_cmd_t  port0_o,
	output testchip_pkg::sram_cmd_t  port1_o,
	output logic [NUM_SRAMS-1:0]     csb0_o,
	output logic [NUM_SRAMS-1:0]     csb1_o
);

	import testchip_pkg::*;

	logic csb0_masked;
	logic csb1_masked;

	// one-hot active low select for a single port
	// selects at or above NUM_SRAMS never match a bank index and leave all ones
	function automatic logic [NUM_SRAMS-1:0] expand_csb(
		input logic                csb,
		input logic [SELECT_W-1:0] sel
	);
		logic [NUM_SRAMS-1:0] vec;
		vec = '1;
		for (int i = 0; i < NUM_SRAMS; i++) begin
			if (!csb && (sel == SELECT_W'(i))) begin
				vec[i] = 1'b0;
			end
		end
		return vec;
	endfunction

	// global_csb overrides the per port field
	assign csb0_masked = global_csb_i | scan_word_i.port0.csb;
	assign csb1_masked = global_csb_i | scan_word_i.port1.csb;

	// shared command buses go to all banks
	// only the csb vectors pick out the target
	always_comb begin
		port0_o     = scan_word_i.port0;
		port0_o.csb = csb0_masked;
		port1_o     = scan_word_i.port1;
		port1_o.csb = csb1_masked;
	end

	always_comb begin
		csb0_o = expand_csb(csb0_masked, scan_word_i.chip_sel);
		csb1_o = expand_csb(csb1_masked, scan_word_i.chip_sel);
	end

endmodule

/* design/readback_mux.sv */
`timescale 1ns/1ps

module readback_mux #(
	parameter int NUM_SRAMS = 16
) (
	input  logic [testchip_pkg::SELECT_W-1:0] chip_sel_i,
	input  testchip_pkg::rdata_pair_t         sram_rdata_i [NUM_SRAMS],
	output testchip_pkg::rdata_pair_t         read_pair_o
);

	import testchip_pkg::*;

	// pick the dout pair of the selected bank
	// unpopulated selects read back as zero so a bad select is visible
	always_comb begin
		read_pair_o = '0;
		for (int i = 0; i < NUM_SRAMS; i++) begin
			if (chip_sel_i == SELECT_W'(i)) begin
				read_pair_o = sram_rdata_i[i];
			end
		end
	end

endmodule

/* design/openram_testchip.sv */
`timescale 1ns/1ps

module openram_testchip #(
	parameter int NUM_SRAMS = 16  // at most 2**SELECT_W banks
) (
	input  logic                      clk,
	input  logic                      resetn,

	// gpio scan chain
	input  logic                      gpio_in_i,
	input  logic                      gpio_scan_i,
	input  logic                      gpio_sram_load_i,
	output logic                      gpio_out_o,

	// logic analyzer side
	input  logic                      la_in_load_i,
	input  logic                      la_sram_load_i,
	input  testchip_pkg::scan_word_t  la_data_i,
	output testchip_pkg::scan_word_t  la_data_o,

	input  logic                      global_csb_i,

	// sram macros
	input  testchip_pkg::rdata_pair_t sram_rdata_i [NUM_SRAMS],
	output testchip_pkg::sram_cmd_t   port0_o,
	output testchip_pkg::sram_cmd_t   port1_o,
	output logic [NUM_SRAMS-1:0]      csb0_o,  // one per bank, active low
	output logic [NUM_SRAMS-1:0]      csb1_o
);

	import testchip_pkg::*;

	scan_word_t  scan_word;
	rdata_pair_t read_pair;
	logic        capture;

	// either strobe samples the read data
	assign capture = gpio_sram_load_i | la_sram_load_i;

	scan_register u_scan_register (
		.clk          (clk),
		.resetn       (resetn),
		.gpio_in_i    (gpio_in_i),
		.gpio_scan_i  (gpio_scan_i),
		.la_in_load_i (la_in_load_i),
		.capture_i    (capture),
		.la_data_i    (la_data_i),
		.read_pair_i  (read_pair),
		.scan_word_o  (scan_word)
	);

	port_decoder #(
		.NUM_SRAMS (NUM_SRAMS)
	) u_port_decoder (
		.scan_word_i  (scan_word),
		.global_csb_i (global_csb_i),
		.port0_o      (port0_o),
		.port1_o      (port1_o),
		.csb0_o       (csb0_o),
		.csb1_o       (csb1_o)
	);

	readback_mux #(
		.NUM_SRAMS (NUM_SRAMS)
	) u_readback_mux (
		.chip_sel_i   (scan_word.chip_sel),
		.sram_rdata_i (sram_rdata_i),
		.read_pair_o  (read_pair)
	);

	// readback of the word itself
	assign la_data_o  = scan_word;
	assign gpio_out_o = scan_word[SCAN_W-1];  // scan-out is msb first

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_o,
	output logic resetn_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// reset low for a fixed number of rising edges, released on an edge
	initial begin
		resetn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		resetn_o <= 1'b1;
	end

endmodule

/* verification/tb_openram_testchip.sv */
`timescale 1ns/1ps

module tb_openram_testchip;

	import testchip_pkg::*;

	localparam int NUM_SRAMS     = 16;
	localparam int RESET_TIMEOUT = 20;  // cycles

	// strobes raised together on one edge
	typedef struct packed {
		logic scan;
		logic in_load;
		logic gpio_cap;
		logic la_cap;
	} strobes_t;

	typedef struct packed {
		load_op_t   op;
		logic       cap_gpio;  // capture through gpio_sram_load instead of la_sram_load
		strobes_t   extra;     // further strobes high in the same cycle
		scan_word_t la_data;
		logic       global_csb;
		logic       gpio_bit;
	} entry_t;

	logic                 clk;
	logic                 resetn;
	logic                 gpio_in;
	logic                 gpio_scan;
	logic                 gpio_sram_load;
	logic                 la_in_load;
	logic                 la_sram_load;
	logic                 global_csb;
	scan_word_t           la_data;
	rdata_pair_t          sram_rdata [NUM_SRAMS];
	logic                 gpio_out;
	scan_word_t           la_data_out;
	sram_cmd_t            port0;
	sram_cmd_t            port1;
	logic [NUM_SRAMS-1:0] csb0;
	logic [NUM_SRAMS-1:0] csb1;

	entry_t     table_q[$];
	scan_word_t model_word;  // reference copy of the scan register

	tb_clock_gen #(
		.PERIOD_NS    (8),
		.RESET_CYCLES (4)
	) u_clock_gen (
		.clk_o    (clk),
		.resetn_o (resetn)
	);

	openram_testchip #(
		.NUM_SRAMS (NUM_SRAMS)
	) dut0 (
		.clk              (clk),
		.resetn           (resetn),
		.gpio_in_i        (gpio_in),
		.gpio_scan_i      (gpio_scan),
		.gpio_sram_load_i (gpio_sram_load),
		.gpio_out_o       (gpio_out),
		.la_in_load_i     (la_in_load),
		.la_sram_load_i   (la_sram_load),
		.la_data_i        (la_data),
		.la_data_o        (la_data_out),
		.global_csb_i     (global_csb),
		.sram_rdata_i     (sram_rdata),
		.port0_o          (port0),
		.port1_o          (port1),
		.csb0_o           (csb0),
		.csb1_o           (csb1)
	);

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input scan_word_t got, input scan_word_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_cmd(input sram_cmd_t got, input sram_cmd_t exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_csb(input logic [NUM_SRAMS-1:0] got, input logic [NUM_SRAMS-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	function automatic scan_word_t rand_word();
		logic [127:0] raw;
		raw = {$urandom(), $urandom(), $urandom(), $urandom()};
		return raw[SCAN_W-1:0];
	endfunction

	// command as the banks see it, csb forced high by the global select
	function automatic sram_cmd_t expected_cmd(input sram_cmd_t field, input logic gcsb);
		sram_cmd_t cmd;
		cmd     = field;
		cmd.csb = field.csb | gcsb;
		return cmd;
	endfunction

	function automatic logic [NUM_SRAMS-1:0] expected_csb(input logic csb_field, input logic gcsb,
			input logic [SELECT_W-1:0] sel);
		logic [NUM_SRAMS-1:0] vec;
		vec = '1;
		if (!gcsb && !csb_field && int'(sel) < NUM_SRAMS) begin
			vec[int'(sel)] = 1'b0;
		end
		return vec;
	endfunction

	function automatic strobes_t strobes_of(input entry_t e);
		strobes_t s;
		s = e.extra;
		case (e.op)
			OP_SHIFT:   s.scan = 1'b1;
			OP_LOAD:    s.in_load = 1'b1;
			OP_CAPTURE: begin
				if (e.cap_gpio) begin
					s.gpio_cap = 1'b1;
				end else begin
					s.la_cap = 1'b1;
				end
			end
			default: ;
		endcase
		return s;
	endfunction

	// shift over load over capture over hold
	function automatic scan_word_t next_word(input scan_word_t w, input strobes_t s,
			input logic bit_in, input scan_word_t la);
		scan_word_t  n;
		rdata_pair_t pair;
		n    = w;
		pair = '0;  // out of range banks read as zero
		if (int'(w.chip_sel) < NUM_SRAMS) begin
			pair = sram_rdata[w.chip_sel];
		end
		if (s.scan) begin
			n = {w[SCAN_W-2:0], bit_in};
		end else if (s.in_load) begin
			n = la;
		end else if (s.gpio_cap || s.la_cap) begin
			n.port0.din = pair.data0;
			n.port1.din = pair.data1;
		end
		return n;
	endfunction

	task automatic check_outputs(input logic gcsb);
		check_word(la_data_out, model_word, "la_data_o");
		check_bit(gpio_out, model_word[SCAN_W-1], "gpio_out_o");
		check_cmd(port0, expected_cmd(model_word.port0, gcsb), "port0_o");
		check_cmd(port1, expected_cmd(model_word.port1, gcsb), "port1_o");
		check_csb(csb0, expected_csb(model_word.port0.csb, gcsb, model_word.chip_sel), "csb0_o");
		check_csb(csb1, expected_csb(model_word.port1.csb, gcsb, model_word.chip_sel), "csb1_o");
	endtask

	task automatic add_entry(input load_op_t op, input logic cap_gpio, input strobes_t extra,
			input scan_word_t la, input logic gcsb, input logic bit_in);
		entry_t e;
		e.op         = op;
		e.cap_gpio   = cap_gpio;
		e.extra      = extra;
		e.la_data    = la;
		e.global_csb = gcsb;
		e.gpio_bit   = bit_in;
		table_q.push_back(e);
	endtask

	task automatic add_hold(input logic gcsb);
		add_entry(OP_HOLD, 1'b0, '0, '0, gcsb, 1'b0);
	endtask

	task automatic add_load(input scan_word_t w, input logic gcsb);
		add_entry(OP_LOAD, 1'b0, '0, w, gcsb, 1'b0);
	endtask

	task automatic build_table();
		scan_word_t          w;
		scan_word_t          target;
		strobes_t            x;
		logic [SELECT_W-1:0] bank;
		// parallel loads, each seen with the global select low and then high
		for (int i = 0; i < 8; i++) begin
			w = rand_word();
			if (i == 1) begin
				w.chip_sel  = SELECT_W'(15);
				w.port0.csb = 1'b0;
				w.port1.csb = 1'b0;
			end
			if (i == 2) begin
				w.port0.csb = 1'b1;
				w.port1.csb = 1'b1;
			end
			add_load(w, 1'($urandom()));
			add_hold(1'b0);
			add_hold(1'b1);
		end
		// capture from several banks, both strobe sources
		for (int b = 0; b < 6; b++) begin
			bank       = (b < 4) ? SELECT_W'(b * 5) : SELECT_W'($urandom());
			w          = rand_word();
			w.chip_sel = bank;
			add_load(w, 1'b0);
			add_entry(OP_CAPTURE, b[0], '0, rand_word(), 1'b0, 1'($urandom()));
			add_hold(1'b0);
		end
		// scan a known word in msb first, the old word comes out on gpio
		add_load(rand_word(), 1'b1);
		target = rand_word();
		for (int i = SCAN_W - 1; i >= 0; i--) begin
			add_entry(OP_SHIFT, 1'b0, '0, '0, 1'($urandom()), target[i]);
		end
		add_hold(1'b0);
		// several strobes at once
		add_load(rand_word(), 1'b0);
		x = '0;
		x.in_load  = 1'b1;
		x.gpio_cap = 1'b1;
		x.la_cap   = 1'b1;
		add_entry(OP_SHIFT, 1'b0, x, rand_word(), 1'b0, 1'b1);  // shift wins
		x = '0;
		x.gpio_cap = 1'b1;
		x.la_cap   = 1'b1;
		add_entry(OP_LOAD, 1'b0, x, rand_word(), 1'b0, 1'b0);   // load over capture
		x = '0;
		x.in_load = 1'b1;
		add_entry(OP_SHIFT, 1'b0, x, rand_word(), 1'b0, 1'b0);
		add_entry(OP_CAPTURE, 1'b1, '0, rand_word(), 1'b0, 1'b1);
		add_hold(1'b0);
		// random mix of everything
		for (int i = 0; i < 24; i++) begin
			x = strobes_t'(4'($urandom()));
			if (i % 2 == 0) begin
				x = '0;
			end
			add_entry(load_op_t'(2'($urandom())), 1'($urandom()), x, rand_word(),
				1'($urandom()), 1'($urandom()));
		end
		add_hold(1'b1);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (resetn !== 1'b1) begin
			if (cycles >= RESET_TIMEOUT) begin
				$display("reset was not released within %0d cycles", RESET_TIMEOUT);
				abort_run();
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
	endtask

	// drive on the edge, check the previous result at the falling edge
	task automatic apply_entry(input entry_t e);
		strobes_t s;
		s = strobes_of(e);
		@(posedge clk);
		gpio_scan      <= s.scan;
		la_in_load     <= s.in_load;
		gpio_sram_load <= s.gpio_cap;
		la_sram_load   <= s.la_cap;
		gpio_in        <= e.gpio_bit;
		global_csb     <= e.global_csb;
		la_data        <= e.la_data;
		@(negedge clk);
		check_outputs(e.global_csb);
		model_word = next_word(model_word, s, e.gpio_bit, e.la_data);
	endtask

	initial begin
		gpio_in        <= 1'b0;
		gpio_scan      <= 1'b0;
		gpio_sram_load <= 1'b0;
		la_in_load     <= 1'b0;
		la_sram_load   <= 1'b0;
		global_csb     <= 1'b1;  // banks off through reset
		la_data        <= '0;
		void'($urandom(8280));
		for (int b = 0; b < NUM_SRAMS; b++) begin
			sram_rdata[b].data0 = $urandom();
			sram_rdata[b].data1 = $urandom();
		end
		build_table();
		model_word = '0;
		wait_reset_release();
		@(negedge clk);
		check_outputs(1'b1);  // cleared word, all selects high
		for (int i = 0; i < table_q.size(); i++) begin
			apply_entry(table_q[i]);
		end
		@(posedge clk);
		gpio_scan      <= 1'b0;
		la_in_load     <= 1'b0;
		gpio_sram_load <= 1'b0;
		la_sram_load   <= 1'b0;
		@(negedge clk);
		check_outputs(global_csb);
		$display("test passed");
		$finish;
	end

endmodule

/* src.f */
design/testchip_pkg.sv
design/scan_register.sv
design/port_decoder.sv
design/readback_mux.sv
design/openram_testchip.sv
verification/tb_clock_gen.sv
verification/tb_openram_testchip.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall
TOP        := tb_openram_testchip
RTL_TOP    := openram_testchip
FILELIST   := src.f
OBJ_DIR    := obj_dir
RTL_FILES  := design/testchip_pkg.sv design/scan_register.sv design/port_decoder.sv \
              design/readback_mux.sv design/openram_testchip.sv

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
